/* Bender.yml */
package:
  name: sim_harness

sources:
  - hw/sim_pkg.sv
  - hw/commit_if.sv
  - hw/sim_mem.sv
  - hw/commit_capture.sv
  - hw/commit_fifo.sv
  - hw/commit_report.sv
  - hw/sim_top.sv
  - target: test
    files:
      - testbench/tb_sim_top.sv

/* hw/commit_capture.sv */
`timescale 1ns/10ps

module commit_capture import sim_pkg::*; (
  input  logic       clock,
  input  logic       reset,
  input  logic       fetch_valid_i,
  input  addr_t      fetch_pc_i,
  input  inst_t      fetch_inst_i,
  input  logic       wb_wen_i,
  input  logic       retire_i,
  input  reg_idx_t   wb_rd_i,
  input  data_t      wb_wdata_i,
  input  data_t      a0_i,
  input  logic       full_i,
  commit_if.producer push,
  output logic       overflow_o
);

  addr_t      fetch_pc_q;
  inst_t      fetch_inst_q;
  logic       pend_q;
  addr_t      rec_pc_q;
  inst_t      rec_inst_q;
  logic       rec_wen_q;
  reg_idx_t   rec_wdest_q;
  data_t      rec_wdata_q;
  logic       rec_skip_q;
  logic       rec_trap_q;
  trap_code_t rec_code_q;
  logic       commit_event;

  assign commit_event = wb_wen_i || retire_i;

  // The last fetched instruction is the one that commits next.
  always_ff @(posedge clock) begin
    if (fetch_valid_i) begin
      fetch_pc_q   <= fetch_pc_i;
      fetch_inst_q <= fetch_inst_i;
    end
  end

  // ------------------------------
  // Record build
  // ------------------------------

  always_ff @(posedge clock) begin
    if (commit_event) begin
      rec_pc_q    <= fetch_pc_q;
      rec_inst_q  <= fetch_inst_q;
      rec_wen_q   <= wb_wen_i && (wb_rd_i != '0);
      rec_wdest_q <= wb_rd_i;
      rec_wdata_q <= wb_wdata_i;
      rec_skip_q  <= (fetch_inst_q == SKIP_INST);
      rec_trap_q  <= (fetch_inst_q[6:0] == TRAP_OPCODE);
      rec_code_q  <= a0_i[7:0];
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      pend_q <= 1'b0;
    end else begin
      pend_q <= commit_event;
    end
  end

  // ------------------------------
  // Push
  // ------------------------------

  assign push.strobe = pend_q && !full_i;
  assign push.pc     = rec_pc_q;
  assign push.inst   = rec_inst_q;
  assign push.wen    = rec_wen_q;
  assign push.wdest  = rec_wdest_q;
  assign push.wdata  = rec_wdata_q;
  assign push.skip   = rec_skip_q;
  assign push.trap   = rec_trap_q;
  assign push.code   = rec_code_q;

  // A record that meets a full queue is lost, and that is remembered until reset.
  always_ff @(posedge clock) begin
    if (reset) begin
      overflow_o <= 1'b0;
    end else if (pend_q && full_i) begin
      overflow_o <= 1'b1;
    end
  end

  a_one_event_kind : assert property (
    @(posedge clock) disable iff (reset) !(wb_wen_i && retire_i)
  );

endmodule

/* hw/commit_fifo.sv */
`timescale 1ns/10ps

module commit_fifo import sim_pkg::*; #(
  parameter int unsigned FIFO_DEPTH = 8
) (
  input  logic       clock,
  input  logic       reset,
  commit_if.consumer push,
  input  logic       pop_i,
  output logic       full_o,
  output logic       empty_o,
  commit_if.producer head
);

  localparam int unsigned PTR_BITS = $clog2(FIFO_DEPTH);
  localparam int unsigned REC_BITS = $bits(addr_t) + $bits(inst_t) + 1 + $bits(reg_idx_t)
                                   + $bits(data_t) + 2 + $bits(trap_code_t);

  logic [REC_BITS-1:0] buf_q [FIFO_DEPTH];
  logic [PTR_BITS-1:0] wr_ptr_q;
  logic [PTR_BITS-1:0] rd_ptr_q;
  logic [PTR_BITS:0]   count_q;
  logic                do_push;
  logic                do_pop;

  assign full_o  = (count_q == FIFO_DEPTH[PTR_BITS:0]);
  assign empty_o = (count_q == '0);
  assign do_push = push.strobe && !full_o;
  assign do_pop  = pop_i && !empty_o;

  always_ff @(posedge clock) begin
    if (do_push) begin
      buf_q[wr_ptr_q] <= {push.pc, push.inst, push.wen, push.wdest,
                          push.wdata, push.skip, push.trap, push.code};
    end
  end

  // Pointers wrap on their own since the depth is a power of two.
  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // The head record is shown in the pop cycle itself.
  assign head.strobe = do_pop;
  assign {head.pc, head.inst, head.wen, head.wdest,
          head.wdata, head.skip, head.trap, head.code} = buf_q[rd_ptr_q];

  a_no_push_when_full : assert property (
    @(posedge clock) disable iff (reset) push.strobe |-> !full_o
  );

endmodule

/* hw/commit_if.sv */
`timescale 1ns/10ps

// One commit record. A record moves in every cycle with strobe high.
interface commit_if import sim_pkg::*; ();

  logic       strobe;
  addr_t      pc;
  inst_t      inst;
  logic       wen;
  reg_idx_t   wdest;
  data_t      wdata;
  logic       skip;
  logic       trap;
  trap_code_t code;

  modport producer (
    output strobe, pc, inst, wen, wdest, wdata, skip, trap, code
  );

  modport consumer (
    input strobe, pc, inst, wen, wdest, wdata, skip, trap, code
  );

endinterface

/* hw/commit_report.sv */
`timescale 1ns/10ps

module commit_report import sim_pkg::*; (
  input  logic       clock,
  input  logic       reset,
  input  logic       empty_i,
  input  logic       hold_i,
  output logic       pop_o,
  commit_if.consumer head,
  output logic       commit_valid_o,
  output logic       commit_wen_o,
  output logic       commit_skip_o,
  output addr_t      commit_pc_o,
  output inst_t      commit_inst_o,
  output reg_idx_t   commit_wdest_o,
  output data_t      commit_wdata_o,
  output logic       trap_valid_o,
  output trap_code_t trap_code_o,
  output count_t     cycle_count_o,
  output count_t     instr_count_o
);

  typedef enum logic {
    RUN,
    HALTED
  } state_t;

  state_t state_q;
  logic   trap_seen;

  // Nothing leaves the queue once the trap has been reported.
  assign pop_o     = (state_q == RUN) && !empty_i && !hold_i;
  assign trap_seen = head.strobe && head.trap;

  // ------------------------------
  // Control and counters
  // ------------------------------

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q        <= RUN;
      commit_valid_o <= 1'b0;
      trap_valid_o   <= 1'b0;
      cycle_count_o  <= '0;
      instr_count_o  <= '0;
    end else begin
      commit_valid_o <= head.strobe;
      trap_valid_o   <= trap_seen;
      if (state_q == RUN) begin
        cycle_count_o <= cycle_count_o + 1'b1;
        if (trap_seen) begin
          state_q <= HALTED;
        end
      end
      if (head.strobe) begin
        instr_count_o <= instr_count_o + 1'b1;
      end
    end
  end

  // ------------------------------
  // Record outputs
  // ------------------------------

  always_ff @(posedge clock) begin
    if (head.strobe) begin
      commit_pc_o    <= head.pc;
      commit_inst_o  <= head.inst;
      commit_wen_o   <= head.wen;
      commit_wdest_o <= head.wdest;
      commit_wdata_o <= head.wdata;
      commit_skip_o  <= head.skip;
      trap_code_o    <= head.code;
    end
  end

  // A trap pulse comes only with the commit of a trap instruction.
  a_trap_with_commit : assert property (
    @(posedge clock) disable iff (reset)
    trap_valid_o |-> (commit_valid_o && (commit_inst_o[6:0] == TRAP_OPCODE))
  );

endmodule

/* hw/sim_mem.sv */
`timescale 1ns/10ps

module sim_mem import sim_pkg::*; #(
  parameter int unsigned MEM_ADDR_BITS = 16
) (
  input  logic   clock,
  input  logic   reset,
  input  logic   cen_i,
  input  logic   wen_i,
  input  addr_t  addr_i,
  input  data_t  wdata_i,
  input  wmask_t wmask_i,
  input  size_t  size_i,
  output logic   ready_o,
  output data_t  rdata_o
);

  localparam int unsigned WORDS = 2 ** MEM_ADDR_BITS;

  data_t                    mem_q [WORDS];
  addr_t                    offset;
  logic [MEM_ADDR_BITS-1:0] word_idx;
  data_t                    lane_mask;

  // ------------------------------
  // Address and lane decode
  // ------------------------------

  // Bits above the index range are dropped, so the array repeats through the address space.
  assign offset   = addr_i - PC_START;
  assign word_idx = offset[MEM_ADDR_BITS+2:3];

  always_comb begin
    for (int i = 0; i < $bits(wmask_t); i++) begin
      lane_mask[i*8 +: 8] = {8{wmask_i[i]}};
    end
  end

  // ------------------------------
  // Storage
  // ------------------------------

  always_ff @(posedge clock) begin
    if (cen_i && wen_i) begin
      mem_q[word_idx] <= (mem_q[word_idx] & ~lane_mask) | (wdata_i & lane_mask);
    end
  end

  // Read data stays put until the next read request.
  always_ff @(posedge clock) begin
    if (cen_i && !wen_i) begin
      rdata_o <= mem_q[word_idx];
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      ready_o <= 1'b0;
    end else begin
      ready_o <= cen_i;
    end
  end

  // A write must touch at least one lane.
  a_write_req_legal : assert property (
    @(posedge clock) disable iff (reset)
    (cen_i && wen_i) |-> (wmask_i != '0)
  );

endmodule

/* hw/sim_pkg.sv */
package sim_pkg;

  // ------------------------------
  // Widths
  // ------------------------------

  // Byte address on the memory port, also used for pc values.
  typedef logic [63:0] addr_t;

  // Memory word and writeback data.
  typedef logic [63:0] data_t;

  typedef logic [31:0] inst_t;

  // One enable bit per byte lane of a data_t word.
  typedef logic [7:0] wmask_t;

  // Access size code from the core, carried but not decoded.
  typedef logic [2:0] size_t;

  typedef logic [4:0] reg_idx_t;

  // Low byte of a0 when the trap instruction retires.
  typedef logic [7:0] trap_code_t;

  typedef logic [63:0] count_t;

  // ------------------------------
  // Constants
  // ------------------------------

  // Program base. Every memory address is taken relative to it.
  localparam addr_t PC_START = 64'h0000_0000_8000_0000;

  // Opcode of the custom instruction that ends a simulation run.
  localparam logic [6:0] TRAP_OPCODE = 7'h6b;

  // Commits of this instruction are flagged so the checker skips them.
  localparam inst_t SKIP_INST = 32'h0000_007b;

endpackage

/* hw/sim_top.sv */
`timescale 1ns/10ps

module sim_top import sim_pkg::*; #(
  parameter int unsigned MEM_ADDR_BITS = 16,
  parameter int unsigned FIFO_DEPTH    = 8
) (
  input  logic       clock,
  input  logic       reset,
  // Memory port.
  input  logic       mem_cen_i,
  input  logic       mem_wen_i,
  input  addr_t      mem_addr_i,
  input  data_t      mem_wdata_i,
  input  wmask_t     mem_wmask_i,
  input  size_t      mem_size_i,
  output logic       mem_ready_o,
  output data_t      mem_rdata_o,
  // Core events.
  input  logic       fetch_valid_i,
  input  addr_t      fetch_pc_i,
  input  inst_t      fetch_inst_i,
  input  logic       wb_wen_i,
  input  logic       retire_i,
  input  reg_idx_t   wb_rd_i,
  input  data_t      wb_wdata_i,
  input  data_t      a0_i,
  input  logic       trace_hold_i,
  // Commit trace.
  output logic       commit_valid_o,
  output logic       commit_wen_o,
  output logic       commit_skip_o,
  output addr_t      commit_pc_o,
  output inst_t      commit_inst_o,
  output reg_idx_t   commit_wdest_o,
  output data_t      commit_wdata_o,
  output logic       trap_valid_o,
  output trap_code_t trap_code_o,
  output count_t     cycle_count_o,
  output count_t     instr_count_o,
  output logic       overflow_o
);

  logic fifo_full;
  logic fifo_empty;
  logic fifo_pop;

  commit_if push_if ();
  commit_if head_if ();

  // ------------------------------
  // Memory model
  // ------------------------------

  sim_mem #(
    .MEM_ADDR_BITS (MEM_ADDR_BITS)
  ) u_mem (
    .clock   (clock),
    .reset   (reset),
    .cen_i   (mem_cen_i),
    .wen_i   (mem_wen_i),
    .addr_i  (mem_addr_i),
    .wdata_i (mem_wdata_i),
    .wmask_i (mem_wmask_i),
    .size_i  (mem_size_i),
    .ready_o (mem_ready_o),
    .rdata_o (mem_rdata_o)
  );

  // ------------------------------
  // Commit tracer
  // ------------------------------

  commit_capture u_capture (
    .clock         (clock),
    .reset         (reset),
    .fetch_valid_i (fetch_valid_i),
    .fetch_pc_i    (fetch_pc_i),
    .fetch_inst_i  (fetch_inst_i),
    .wb_wen_i      (wb_wen_i),
    .retire_i      (retire_i),
    .wb_rd_i       (wb_rd_i),
    .wb_wdata_i    (wb_wdata_i),
    .a0_i          (a0_i),
    .full_i        (fifo_full),
    .push          (push_if.producer),
    .overflow_o    (overflow_o)
  );

  commit_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_fifo (
    .clock   (clock),
    .reset   (reset),
    .push    (push_if.consumer),
    .pop_i   (fifo_pop),
    .full_o  (fifo_full),
    .empty_o (fifo_empty),
    .head    (head_if.producer)
  );

  commit_report u_report (
    .clock          (clock),
    .reset          (reset),
    .empty_i        (fifo_empty),
    .hold_i         (trace_hold_i),
    .pop_o          (fifo_pop),
    .head           (head_if.consumer),
    .commit_valid_o (commit_valid_o),
    .commit_wen_o   (commit_wen_o),
    .commit_skip_o  (commit_skip_o),
    .commit_pc_o    (commit_pc_o),
    .commit_inst_o  (commit_inst_o),
    .commit_wdest_o (commit_wdest_o),
    .commit_wdata_o (commit_wdata_o),
    .trap_valid_o   (trap_valid_o),
    .trap_code_o    (trap_code_o),
    .cycle_count_o  (cycle_count_o),
    .instr_count_o  (instr_count_o)
  );

endmodule

/* testbench/tb_sim_top.sv */
`timescale 1ns/10ps

module tb_sim_top import sim_pkg::*; ();

  localparam int unsigned MEM_ADDR_BITS = 16;
  localparam int unsigned FIFO_DEPTH    = 8;
  localparam int unsigned WAIT_LIMIT    = 40;
  localparam addr_t       MEM_BASE      = PC_START + 64'h100;

  logic       clock, reset;
  logic       mem_cen_i, mem_wen_i, mem_ready_o;
  addr_t      mem_addr_i;
  data_t      mem_wdata_i, mem_rdata_o;
  wmask_t     mem_wmask_i;
  size_t      mem_size_i;
  logic       fetch_valid_i, wb_wen_i, retire_i, trace_hold_i;
  addr_t      fetch_pc_i, commit_pc_o;
  inst_t      fetch_inst_i, commit_inst_o;
  reg_idx_t   wb_rd_i, commit_wdest_o;
  data_t      wb_wdata_i, a0_i, commit_wdata_o;
  logic       commit_valid_o, commit_wen_o, commit_skip_o, trap_valid_o, overflow_o;
  trap_code_t trap_code_o;
  count_t     cycle_count_o, instr_count_o;

  logic [31:0] lfsr_q;
  int unsigned expected_commits;
  addr_t       exp_pc    [FIFO_DEPTH+1];
  inst_t       exp_inst  [FIFO_DEPTH+1];
  reg_idx_t    exp_rd    [FIFO_DEPTH+1];
  data_t       exp_wdata [FIFO_DEPTH+1];

  sim_top #(
    .MEM_ADDR_BITS (MEM_ADDR_BITS),
    .FIFO_DEPTH    (FIFO_DEPTH)
  ) u_dut (
    .clock          (clock),
    .reset          (reset),
    .mem_cen_i      (mem_cen_i),
    .mem_wen_i      (mem_wen_i),
    .mem_addr_i     (mem_addr_i),
    .mem_wdata_i    (mem_wdata_i),
    .mem_wmask_i    (mem_wmask_i),
    .mem_size_i     (mem_size_i),
    .mem_ready_o    (mem_ready_o),
    .mem_rdata_o    (mem_rdata_o),
    .fetch_valid_i  (fetch_valid_i),
    .fetch_pc_i     (fetch_pc_i),
    .fetch_inst_i   (fetch_inst_i),
    .wb_wen_i       (wb_wen_i),
    .retire_i       (retire_i),
    .wb_rd_i        (wb_rd_i),
    .wb_wdata_i     (wb_wdata_i),
    .a0_i           (a0_i),
    .trace_hold_i   (trace_hold_i),
    .commit_valid_o (commit_valid_o),
    .commit_wen_o   (commit_wen_o),
    .commit_skip_o  (commit_skip_o),
    .commit_pc_o    (commit_pc_o),
    .commit_inst_o  (commit_inst_o),
    .commit_wdest_o (commit_wdest_o),
    .commit_wdata_o (commit_wdata_o),
    .trap_valid_o   (trap_valid_o),
    .trap_code_o    (trap_code_o),
    .cycle_count_o  (cycle_count_o),
    .instr_count_o  (instr_count_o),
    .overflow_o     (overflow_o)
  );

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  // ------------------------------
  // Helpers
  // ------------------------------

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("Simulation failed");
    $fatal(1, reason);
  endtask

  task automatic check(input string name, input logic [63:0] actual, input logic [63:0] expected);
    if (actual !== expected) begin
      $display("Error at %0t: %s is %h, expected %h", $time, name, actual, expected);
      fail_run("A DUT output did not match its expected value.");
    end
  endtask

  // Taps 32, 22, 2 and 1.
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic random_bits(input int n, output logic [63:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      val    = {val[62:0], lfsr_q[31]};
    end
  endtask

  task automatic step();
    @(posedge clock);
    #1;
  endtask

  // Each commit the tests wait for adds one to the expected instruction count.
  task automatic wait_commit();
    int cycles;
    cycles = 0;
    step();
    while (!commit_valid_o && cycles < WAIT_LIMIT) begin
      step();
      cycles++;
    end
    if (!commit_valid_o) begin
      fail_run("No commit was reported within the timeout.");
    end
    expected_commits++;
  endtask

  task automatic mem_request(input logic wen, input addr_t addr, input data_t wdata,
                             input wmask_t mask, output data_t rdata);
    check("mem_ready_o", mem_ready_o, 0);
    mem_cen_i   = 1'b1;
    mem_wen_i   = wen;
    mem_addr_i  = addr;
    mem_wdata_i = wdata;
    mem_wmask_i = mask;
    step();
    check("mem_ready_o", mem_ready_o, 1);
    rdata     = mem_rdata_o;
    mem_cen_i = 1'b0;
    mem_wen_i = 1'b0;
    step();
    check("mem_ready_o", mem_ready_o, 0);
  endtask

  task automatic fetch(input addr_t pc, input inst_t inst);
    fetch_valid_i = 1'b1;
    fetch_pc_i    = pc;
    fetch_inst_i  = inst;
    step();
    fetch_valid_i = 1'b0;
  endtask

  task automatic writeback(input reg_idx_t rd, input data_t wdata);
    wb_wen_i   = 1'b1;
    wb_rd_i    = rd;
    wb_wdata_i = wdata;
    step();
    wb_wen_i = 1'b0;
  endtask

  task automatic retire(input data_t a0);
    retire_i = 1'b1;
    a0_i     = a0;
    step();
    retire_i = 1'b0;
  endtask

  // ------------------------------
  // Directed tests
  // ------------------------------

  task automatic test_mem_masking();
    data_t  full_word, part_word, expected, rdata;
    wmask_t mask;
    random_bits(64, full_word);
    random_bits(64, part_word);
    mask = 8'ha5;
    for (int i = 0; i < 8; i++) begin
      expected[i*8 +: 8] = mask[i] ? part_word[i*8 +: 8] : full_word[i*8 +: 8];
    end
    mem_request(1'b1, MEM_BASE, full_word, 8'hff, rdata);
    mem_request(1'b1, MEM_BASE, part_word, mask, rdata);
    mem_request(1'b0, MEM_BASE, '0, '0, rdata);
    check("mem_rdata_o", rdata, expected);
    mem_request(1'b0, MEM_BASE + (64'd1 << (MEM_ADDR_BITS + 3)), '0, '0, rdata);
    check("mem_rdata_o", rdata, expected);
    // A write leaves the last read data in place.
    mem_request(1'b1, MEM_BASE + 64'h8, full_word, 8'hff, rdata);
    check("mem_rdata_o", mem_rdata_o, expected);
  endtask

  task automatic test_commit_latency();
    addr_t       pc;
    data_t       wdata;
    logic [63:0] r;
    random_bits(64, pc);
    random_bits(25, r);
    random_bits(64, wdata);
    fetch(pc, {r[24:0], 7'h13});
    wb_wen_i   = 1'b1;
    wb_rd_i    = 5'd7;
    wb_wdata_i = wdata;
    for (int i = 1; i <= 3; i++) begin
      step();
      wb_wen_i = 1'b0;
      check("commit_valid_o", commit_valid_o, (i == 3) ? 1 : 0);
    end
    expected_commits++;
    check("commit_pc_o", commit_pc_o, pc);
    check("commit_inst_o", commit_inst_o, {r[24:0], 7'h13});
    check("commit_wen_o", commit_wen_o, 1);
    check("commit_wdest_o", commit_wdest_o, 7);
    check("commit_wdata_o", commit_wdata_o, wdata);
  endtask

  task automatic test_flags();
    fetch(PC_START + 64'h40, 32'h0010_0093);
    writeback(5'd0, 64'h1234);
    wait_commit();
    check("commit_wen_o", commit_wen_o, 0);
    check("commit_skip_o", commit_skip_o, 0);
    fetch(PC_START + 64'h44, SKIP_INST);
    retire(64'h0);
    wait_commit();
    check("commit_skip_o", commit_skip_o, 1);
    check("commit_wen_o", commit_wen_o, 0);
    fetch(PC_START + 64'h48, 32'h0000_0013);
    retire(64'h0);
    wait_commit();
    check("commit_skip_o", commit_skip_o, 0);
  endtask

  task automatic test_buffering(input int n);
    int          shown;
    logic [63:0] r;
    trace_hold_i = 1'b1;
    for (int i = 0; i < n; i++) begin
      random_bits(64, r);
      exp_pc[i] = r;
      random_bits(25, r);
      exp_inst[i] = {r[24:0], 7'h13};
      random_bits(5, r);
      exp_rd[i] = r[4:0];
      random_bits(64, r);
      exp_wdata[i] = r;
      fetch(exp_pc[i], exp_inst[i]);
      writeback(exp_rd[i], exp_wdata[i]);
    end
    step();
    step();
    check("commit_valid_o", commit_valid_o, 0);
    check("overflow_o", overflow_o, (n > FIFO_DEPTH) ? 1 : 0);
    shown = (n > FIFO_DEPTH) ? FIFO_DEPTH : n;
    trace_hold_i = 1'b0;
    for (int i = 0; i < shown; i++) begin
      wait_commit();
      check("commit_pc_o", commit_pc_o, exp_pc[i]);
      check("commit_inst_o", commit_inst_o, exp_inst[i]);
      check("commit_wen_o", commit_wen_o, (exp_rd[i] != 0) ? 1 : 0);
      check("commit_wdest_o", commit_wdest_o, exp_rd[i]);
      check("commit_wdata_o", commit_wdata_o, exp_wdata[i]);
    end
    for (int i = 0; i < 2 * FIFO_DEPTH; i++) begin
      step();
      check("commit_valid_o", commit_valid_o, 0);
    end
  endtask

  task automatic test_trap();
    addr_t  pc;
    data_t  a0;
    count_t cycles;
    count_t instrs;
    random_bits(64, pc);
    random_bits(64, a0);
    fetch(pc, 32'h0000_006b);
    retire(a0);
    wait_commit();
    check("trap_valid_o", trap_valid_o, 1);
    check("trap_code_o", trap_code_o, a0[7:0]);
    check("commit_pc_o", commit_pc_o, pc);
    check("instr_count_o", instr_count_o, expected_commits);
    if (cycle_count_o < instr_count_o) begin
      fail_run("The cycle count is below the instruction count at the trap.");
    end
    cycles = cycle_count_o;
    instrs = instr_count_o;
    fetch(pc + 64'h4, 32'h0000_0013);
    writeback(5'd3, a0);
    fetch(pc + 64'h8, 32'h0000_0013);
    retire(a0);
    for (int i = 0; i < 3 * FIFO_DEPTH; i++) begin
      step();
      check("commit_valid_o", commit_valid_o, 0);
      check("trap_valid_o", trap_valid_o, 0);
    end
    check("instr_count_o", instr_count_o, instrs);
    check("cycle_count_o", cycle_count_o, cycles);
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------

  initial begin
    lfsr_q           = 32'd99721;
    expected_commits = 0;
    reset            = 1'b1;
    mem_cen_i        = 1'b0;
    mem_wen_i        = 1'b0;
    mem_addr_i       = PC_START;
    mem_wdata_i      = '0;
    mem_wmask_i      = '0;
    mem_size_i       = 3'd3;
    fetch_valid_i    = 1'b0;
    fetch_pc_i       = '0;
    fetch_inst_i     = '0;
    wb_wen_i         = 1'b0;
    retire_i         = 1'b0;
    wb_rd_i          = '0;
    wb_wdata_i       = '0;
    a0_i             = '0;
    trace_hold_i     = 1'b0;
    for (int i = 0; i < 16; i++) begin
      step();
    end
    check("mem_ready_o", mem_ready_o, 0);
    check("commit_valid_o", commit_valid_o, 0);
    check("trap_valid_o", trap_valid_o, 0);
    check("overflow_o", overflow_o, 0);
    check("cycle_count_o", cycle_count_o, 0);
    check("instr_count_o", instr_count_o, 0);
    reset = 1'b0;
    test_mem_masking();
    test_commit_latency();
    test_flags();
    test_buffering(FIFO_DEPTH);
    test_buffering(FIFO_DEPTH + 1);
    test_trap();
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

/* verilog.f */
hw/sim_pkg.sv
hw/commit_if.sv
hw/sim_mem.sv
hw/commit_capture.sv
hw/commit_fifo.sv
hw/commit_report.sv
hw/sim_top.sv
testbench/tb_sim_top.sv
